//--- src/psg_cfg_pkg.sv
`default_nettype none

package psg_cfg_pkg;

	// ============================================================
	// sample and channel sizes
	// ============================================================
	localparam int PHASE_W  = 16;
	// 32 entries per channel table
	localparam int WAVE_AW  = 5;
	localparam int SAMPLE_W = 8;
	localparam int VOL_W    = 4;
	// signed sample times unsigned volume
	localparam int SCALED_W = 12;

	// ============================================================
	// host write port
	// ============================================================
	typedef enum logic [1:0] {
		OP_WAVE,
		OP_FREQ,
		OP_VOL,
		OP_ENABLE
	} host_op_e;

	typedef struct packed {
		logic               valid;
		host_op_e           op;
		logic [3:0]         chan;
		logic [WAVE_AW-1:0] index;
		logic [15:0]        data;
	} host_wr_t;

endpackage

`default_nettype wire

//--- src/psg_bus_pkg.sv
`default_nettype none

package psg_bus_pkg;

	import psg_cfg_pkg::*;

	// ============================================================
	// shared wave table bus
	// ============================================================

	// one channel's read request with an index into its own table
	typedef struct packed {
		logic               valid;
		logic [WAVE_AW-1:0] index;
	} wave_req_t;

	// memory reply that comes one cycle after the merged valid
	typedef struct packed {
		logic                ack;
		logic [SAMPLE_W-1:0] data;
	} wave_rsp_t;

	// arbiter holds the grant while busy
	typedef enum logic {
		ARB_IDLE,
		ARB_BUSY
	} arb_state_e;

endpackage

`default_nettype wire

//--- src/psg_bus_arb.sv
`default_nettype none
`timescale 1ns/10ps

module psg_bus_arb
	import psg_bus_pkg::*;
#(
	parameter int NUM_CHAN = 4
) (
	input  logic                     clk,
	input  logic                     rst,
	input  wave_req_t [NUM_CHAN-1:0] req,
	input  wave_rsp_t                rsp,
	output logic [NUM_CHAN-1:0]      grant,
	output wave_req_t                mem_req,
	output logic [3:0]               mem_chan
);

	arb_state_e state;
	logic [3:0] pick_idx;
	logic       pick_found;

	// scan from the top down so the lowest requesting channel wins
	always_comb begin
		pick_idx = 4'd0;
		pick_found = 1'b0;
		for (int i = NUM_CHAN - 1; i >= 0; i--) begin
			if (req[i].valid) begin
				pick_idx = 4'(i);
				pick_found = 1'b1;
			end
		end
	end

	// grant only changes in idle and drops on the ack cycle
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ARB_IDLE;
			grant <= '0;
			mem_chan <= 4'd0;
		end else begin
			case (state)
				ARB_IDLE: begin
					if (pick_found) begin
						grant <= NUM_CHAN'(1) << pick_idx;
						mem_chan <= pick_idx;
						state <= ARB_BUSY;
					end
				end
				ARB_BUSY: begin
					if (rsp.ack) begin
						grant <= '0;
						state <= ARB_IDLE;
					end
				end
				default: state <= ARB_IDLE;
			endcase
		end
	end

	// forward the granted channel's request to memory
	always_comb begin
		mem_req = '0;
		if (state == ARB_BUSY) begin
			mem_req = req[mem_chan];
		end
	end

endmodule

`default_nettype wire

//--- src/wave_mem.sv
`default_nettype none
`timescale 1ns/10ps

module wave_mem
	import psg_cfg_pkg::*;
	import psg_bus_pkg::*;
#(
	parameter int NUM_CHAN = 4
) (
	input  logic       clk,
	input  logic       rst,
	input  host_wr_t   host,
	input  wave_req_t  mem_req,
	input  logic [3:0] mem_chan,
	output wave_rsp_t  rsp
);

	localparam int CW = (NUM_CHAN > 1) ? $clog2(NUM_CHAN) : 1;
	localparam int AW = CW + WAVE_AW;

	// one table of 32 samples per channel with the channel number on top
	logic [SAMPLE_W-1:0] mem [NUM_CHAN << WAVE_AW];
	logic [AW-1:0]       wr_addr;
	logic [AW-1:0]       rd_addr;
	logic                wr_en;
	logic                ack_q;
	logic [SAMPLE_W-1:0] data_q;

	assign wr_addr = {host.chan[CW-1:0], host.index};
	assign rd_addr = {mem_chan[CW-1:0], mem_req.index};
	assign wr_en = host.valid && (host.op == OP_WAVE) && ({1'b0, host.chan} < 5'(NUM_CHAN));

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_addr] <= host.data[SAMPLE_W-1:0];
		end
		if (mem_req.valid) begin
			data_q <= mem[rd_addr];
		end
	end

	// single ack per request because valid is still high on the ack cycle
	always_ff @(posedge clk) begin
		if (rst) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= mem_req.valid && !ack_q;
		end
	end

	assign rsp = '{ack: ack_q, data: data_q};

endmodule

`default_nettype wire

//--- src/wave_channel.sv
`default_nettype none
`timescale 1ns/10ps

module wave_channel
	import psg_cfg_pkg::*;
	import psg_bus_pkg::*;
#(
	parameter int CHAN_ID = 0
) (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       sample_tick,
	input  host_wr_t                   host,
	input  logic                       grant,
	input  wave_rsp_t                  rsp,
	output wave_req_t                  req,
	output logic signed [SCALED_W-1:0] scaled
);

	typedef enum logic {
		FETCH_IDLE,
		FETCH_WAIT
	} fetch_state_e;

	fetch_state_e               state;
	logic [PHASE_W-1:0]         freq;
	logic [PHASE_W-1:0]         phase;
	logic [PHASE_W-1:0]         next_phase;
	logic [VOL_W-1:0]           vol;
	logic                       enable;
	logic                       host_hit;
	logic signed [SCALED_W-1:0] product;

	assign host_hit = host.valid && (host.chan == 4'(CHAN_ID));
	assign next_phase = phase + freq;
	// pad a zero onto the unsigned volume before the signed multiply
	assign product = $signed(rsp.data) * $signed({1'b0, vol});

	// ============================================================
	// configuration registers
	// ============================================================
	always_ff @(posedge clk) begin
		if (rst) begin
			freq <= '0;
			vol <= '0;
			enable <= 1'b0;
		end else if (host_hit) begin
			case (host.op)
				OP_FREQ:   freq <= host.data;
				OP_VOL:    vol <= host.data[VOL_W-1:0];
				OP_ENABLE: enable <= host.data[0];
				default: ;
			endcase
		end
	end

	// ============================================================
	// phase accumulator and fetch FSM
	// ============================================================
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= FETCH_IDLE;
			phase <= '0;
			req <= '0;
			scaled <= '0;
		end else begin
			if (sample_tick && enable) begin
				phase <= next_phase;
			end
			case (state)
				FETCH_IDLE: begin
					// table index is the top bits of the new phase
					if (sample_tick && enable) begin
						req.valid <= 1'b1;
						req.index <= next_phase[PHASE_W-1 -: WAVE_AW];
						state <= FETCH_WAIT;
					end
				end
				FETCH_WAIT: begin
					// request stays up until our own ack even if disabled meanwhile
					if (grant && rsp.ack) begin
						req.valid <= 1'b0;
						state <= FETCH_IDLE;
						scaled <= product;
					end
				end
				default: state <= FETCH_IDLE;
			endcase
			if (!enable) begin
				scaled <= '0;
			end
		end
	end

endmodule

`default_nettype wire

//--- src/psg_mixer.sv
`default_nettype none
`timescale 1ns/10ps

module psg_mixer
	import psg_cfg_pkg::*;
#(
	parameter int NUM_CHAN    = 4,
	parameter int OUT_CREDITS = 4,
	parameter int MIX_W       = SCALED_W + $clog2(NUM_CHAN)
) (
	input  logic                               clk,
	input  logic                               rst,
	input  logic                               sample_tick,
	input  logic [NUM_CHAN-1:0][SCALED_W-1:0]  scaled,
	input  logic                               credit_return,
	output logic                               mix_valid,
	output logic signed [MIX_W-1:0]            mix_sample,
	output logic [7:0]                         overrun
);

	localparam int CRED_W = $clog2(OUT_CREDITS + 1);

	logic [CRED_W-1:0]       credits;
	logic signed [MIX_W-1:0] sum;
	logic                    emit;

	// sign extend each channel before adding
	always_comb begin
		sum = '0;
		for (int i = 0; i < NUM_CHAN; i++) begin
			sum = sum + MIX_W'($signed(scaled[i]));
		end
	end

	assign emit = sample_tick && (credits != '0);

	// ============================================================
	// output credits and overrun count
	// ============================================================
	always_ff @(posedge clk) begin
		if (rst) begin
			credits <= CRED_W'(OUT_CREDITS);
			mix_valid <= 1'b0;
			overrun <= 8'd0;
		end else begin
			mix_valid <= emit;
			case ({emit, credit_return})
				2'b10: credits <= credits - 1'b1;
				2'b01: begin
					// never above the reset level
					if (credits != CRED_W'(OUT_CREDITS)) begin
						credits <= credits + 1'b1;
					end
				end
				default: ;
			endcase
			if (sample_tick && !emit) begin
				overrun <= overrun + 8'd1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (emit) begin
			mix_sample <= sum;
		end
	end

endmodule

`default_nettype wire

//--- src/psg_top.sv
`default_nettype none
`timescale 1ns/10ps

module psg_top
	import psg_cfg_pkg::*;
	import psg_bus_pkg::*;
#(
	parameter int  NUM_CHAN    = 4,
	parameter int  OUT_CREDITS = 4,
	localparam int MIX_W       = SCALED_W + $clog2(NUM_CHAN)
) (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    sample_tick,
	input  host_wr_t                host,
	input  logic                    credit_return,
	output logic                    mix_valid,
	output logic signed [MIX_W-1:0] mix_sample,
	output logic [7:0]              overrun
);

	wave_req_t [NUM_CHAN-1:0]          chan_req;
	logic [NUM_CHAN-1:0]               grant;
	wave_req_t                         mem_req;
	logic [3:0]                        mem_chan;
	wave_rsp_t                         mem_rsp;
	logic [NUM_CHAN-1:0][SCALED_W-1:0] chan_scaled;

	psg_bus_arb #(.NUM_CHAN(NUM_CHAN)) u_arb (
		.clk(clk), .rst(rst), .req(chan_req), .rsp(mem_rsp),
		.grant(grant), .mem_req(mem_req), .mem_chan(mem_chan)
	);

	wave_mem #(.NUM_CHAN(NUM_CHAN)) u_mem (
		.clk(clk), .rst(rst), .host(host),
		.mem_req(mem_req), .mem_chan(mem_chan), .rsp(mem_rsp)
	);

	// one channel per table with its own index
	for (genvar i = 0; i < NUM_CHAN; i++) begin : g_chan
		wave_channel #(.CHAN_ID(i)) u_chan (
			.clk(clk), .rst(rst), .sample_tick(sample_tick), .host(host),
			.grant(grant[i]), .rsp(mem_rsp), .req(chan_req[i]), .scaled(chan_scaled[i])
		);
	end

	psg_mixer #(.NUM_CHAN(NUM_CHAN), .OUT_CREDITS(OUT_CREDITS), .MIX_W(MIX_W)) u_mix (
		.clk(clk), .rst(rst), .sample_tick(sample_tick), .scaled(chan_scaled),
		.credit_return(credit_return), .mix_valid(mix_valid),
		.mix_sample(mix_sample), .overrun(overrun)
	);

endmodule

`default_nettype wire

//--- sim/tb_psg_top.sv
`default_nettype none
`timescale 1ns/10ps

module tb_psg_top
	import psg_cfg_pkg::*;
();

	localparam int NUM_CHAN    = 4;
	localparam int OUT_CREDITS = 4;
	localparam int MIX_W       = SCALED_W + $clog2(NUM_CHAN);
	// 8 + 16 + 10 + 10 + 4 ticks over the five tests
	localparam int TOTAL_TICKS = 48;
	localparam int CYCLE_LIMIT = TOTAL_TICKS * 20 * 3 / 2;

	logic                    clk;
	logic                    rst;
	logic                    sample_tick;
	host_wr_t                host;
	logic                    credit_return;
	logic                    mix_valid;
	logic signed [MIX_W-1:0] mix_sample;
	logic [7:0]              overrun;

	logic [31:0]             lfsr;
	int                      cycles;
	int                      checks;
	int                      errors;
	int                      out_count;
	logic                    auto_credit;
	logic signed [MIX_W-1:0] exp_q[$];

	// reference model state
	logic signed [SAMPLE_W-1:0] m_table[NUM_CHAN][32];
	logic [PHASE_W-1:0]         m_freq[NUM_CHAN];
	logic [PHASE_W-1:0]         m_phase[NUM_CHAN];
	logic [VOL_W-1:0]           m_vol[NUM_CHAN];
	logic                       m_en[NUM_CHAN];
	int                         m_scaled[NUM_CHAN];
	int                         m_credits;
	int                         m_overrun;

	psg_top u_dut (
		.clk(clk), .rst(rst), .sample_tick(sample_tick), .host(host),
		.credit_return(credit_return), .mix_valid(mix_valid),
		.mix_sample(mix_sample), .overrun(overrun)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ============================================================
	// random bits and reference model
	// ============================================================

	// taps 32, 22, 2, 1
	function automatic int take_bits(input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++) begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic void model_reset();
		for (int c = 0; c < NUM_CHAN; c++) begin
			m_freq[c] = '0;
			m_phase[c] = '0;
			m_vol[c] = '0;
			m_en[c] = 1'b0;
			m_scaled[c] = 0;
		end
		m_credits = OUT_CREDITS;
		m_overrun = 0;
	endfunction

	// sum what the last round fetched before running the new round
	function automatic int model_tick();
		int sum;
		sum = 0;
		for (int c = 0; c < NUM_CHAN; c++) begin
			sum += m_scaled[c];
		end
		for (int c = 0; c < NUM_CHAN; c++) begin
			if (m_en[c]) begin
				m_phase[c] = m_phase[c] + m_freq[c];
				m_scaled[c] = int'(m_table[c][m_phase[c][PHASE_W-1 -: WAVE_AW]])
					* int'(m_vol[c]);
			end
		end
		return sum;
	endfunction

	task automatic check_val(input string name, input int got, input int exp);
		checks++;
		assert (got == exp) else begin
			$display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic host_write(input host_op_e op, input int chan, input int index,
			input int data);
		@(negedge clk);
		host.valid = 1'b1;
		host.op = op;
		host.chan = 4'(chan);
		host.index = WAVE_AW'(index);
		host.data = 16'(data);
		case (op)
			OP_WAVE:   m_table[chan][index] = data[7:0];
			OP_FREQ:   m_freq[chan] = 16'(data);
			OP_VOL:    m_vol[chan] = VOL_W'(data);
			OP_ENABLE: begin
				m_en[chan] = data[0];
				if (!data[0]) begin
					m_scaled[chan] = 0;
				end
			end
		endcase
	endtask

	task automatic host_idle();
		@(negedge clk);
		host.valid = 1'b0;
	endtask

	// credit goes back on the cycle after the tick while no emission is possible
	task automatic do_tick(input int settle);
		int exp;
		@(negedge clk);
		sample_tick = 1'b1;
		exp = model_tick();
		if (m_credits > 0) begin
			m_credits--;
			exp_q.push_back(MIX_W'(exp));
		end else begin
			m_overrun++;
		end
		@(negedge clk);
		sample_tick = 1'b0;
		credit_return = auto_credit;
		if (auto_credit && m_credits < OUT_CREDITS) begin
			m_credits++;
		end
		@(negedge clk);
		credit_return = 1'b0;
		repeat (settle - 3) @(negedge clk);
	endtask

	task automatic report_test(input string name, input int base_err);
		checks++;
		assert (exp_q.size() == 0) else begin
			$display("error at %0t: %0d expected outputs never appeared", $time, exp_q.size());
			errors++;
			exp_q.delete();
		end
		$display("test %s: %0d errors", name, errors - base_err);
	endtask

	// ============================================================
	// output compare
	// ============================================================
	always @(negedge clk) begin : compare
		logic signed [MIX_W-1:0] exp_val;
		if (mix_valid === 1'b1) begin
			out_count++;
			checks++;
			assert (exp_q.size() > 0) else begin
				$display("error at %0t: output appeared with no expected value", $time);
				errors++;
			end
			if (exp_q.size() > 0) begin
				exp_val = exp_q.pop_front();
				assert (mix_sample == exp_val) else begin
					$display("mismatch at %0t: mix_sample got %0d expected %0d",
						$time, mix_sample, exp_val);
					errors++;
				end
			end
		end
	end

	initial begin : watchdog
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		$display("error: run did not finish within %0d cycles", CYCLE_LIMIT);
		$display("Testbench failed");
		$finish;
	end

	// ============================================================
	// stimulus
	// ============================================================
	initial begin
		int base_err;
		int base_out;
		rst = 1'b1;
		sample_tick = 1'b0;
		host = '0;
		credit_return = 1'b0;
		auto_credit = 1'b1;
		lfsr = 32'h5d6d_2f25;
		checks = 0;
		errors = 0;
		out_count = 0;
		model_reset();
		repeat (5) @(negedge clk);
		rst = 1'b0;
		for (int c = 0; c < NUM_CHAN; c++) begin
			for (int i = 0; i < 32; i++) begin
				host_write(OP_WAVE, c, i, take_bits(8));
			end
		end
		host_idle();

		// channel 0 alone at full volume
		base_err = errors;
		host_write(OP_FREQ, 0, 0, take_bits(16));
		host_write(OP_VOL, 0, 0, 15);
		host_write(OP_ENABLE, 0, 0, 1);
		host_idle();
		repeat (8) do_tick(20);
		report_test("single_channel", base_err);

		base_err = errors;
		for (int c = 0; c < NUM_CHAN; c++) begin
			host_write(OP_FREQ, c, 0, take_bits(16));
			host_write(OP_VOL, c, 0, take_bits(4));
			host_write(OP_ENABLE, c, 0, 1);
		end
		host_idle();
		repeat (16) do_tick(20);
		report_test("all_channels", base_err);

		base_err = errors;
		repeat (3) do_tick(20);
		host_write(OP_ENABLE, 2, 0, 0);
		host_idle();
		repeat (3) do_tick(20);
		host_write(OP_VOL, 1, 0, 3);
		host_write(OP_VOL, 3, 0, 9);
		host_idle();
		repeat (2) do_tick(20);
		host_write(OP_ENABLE, 2, 0, 1);
		host_idle();
		repeat (2) do_tick(20);
		report_test("disable_and_volume", base_err);

		// sink holds its credits back
		base_err = errors;
		base_out = out_count;
		auto_credit = 1'b0;
		repeat (7) do_tick(20);
		check_val("output count", out_count - base_out, OUT_CREDITS);
		check_val("overrun", int'(overrun), m_overrun);
		repeat (OUT_CREDITS) begin
			@(negedge clk);
			credit_return = 1'b1;
			m_credits++;
			@(negedge clk);
			credit_return = 1'b0;
		end
		auto_credit = 1'b1;
		repeat (3) do_tick(20);
		report_test("back_pressure", base_err);

		// reset lands in the middle of a fetch round
		base_err = errors;
		do_tick(4);
		@(negedge clk);
		rst = 1'b1;
		model_reset();
		repeat (5) @(negedge clk);
		rst = 1'b0;
		base_out = out_count;
		repeat (10) @(negedge clk);
		check_val("output count", out_count - base_out, 0);
		check_val("overrun", int'(overrun), 0);
		repeat (3) do_tick(20);
		report_test("reset_state", base_err);

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- flist.f
src/psg_cfg_pkg.sv
src/psg_bus_pkg.sv
src/psg_bus_arb.sv
src/wave_mem.sv
src/wave_channel.sv
src/psg_mixer.sv
src/psg_top.sv
sim/tb_psg_top.sv

//--- Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --assert -j 0 --top-module tb_psg_top -f flist.f -Mdir obj_dir
	./obj_dir/Vtb_psg_top | tee $(LOG)
	@if grep -q "Testbench failed" $(LOG); then exit 1; fi
	@grep -q "Testbench passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
